// ==== bench/tb_robot.sv ====
module tb_robot;

    localparam int TIMEOUT = 200;

    logic                  clk_50;
    logic                  reset;
    logic                  ir_valid;
    logic [7:0]            ir_code;
    logic                  ir_ready;
    logic                  cam_valid;
    logic [2:0]            cam_direction;
    logic [1:0]            cam_speed;
    logic                  cam_orange;
    logic                  cam_ready;
    logic                  drive_valid;
    robot_pkg::drive_cmd_e drive_state;
    logic                  motor_restart;
    logic                  drive_ready;
    logic [6:0]            hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;

    logic [31:0]           lfsr = 32'h2063;
    logic [3:0]            expected_q[$];       // {changed, cmd}
    int                    cycle = 0;
    int                    xfer_cycle = 0;      // Cycle of the last IR transfer
    logic                  stall_en = 1'b0;
    logic                  next_ready;
    robot_pkg::mode_e      m_mode = robot_pkg::IDLE;
    robot_pkg::cam_state_e m_state = robot_pkg::PAUSE;
    logic [7:0]            codes[9] = '{robot_pkg::BTN_CAM, robot_pkg::BTN_IR, robot_pkg::BTN_IDLE,
        robot_pkg::BTN_STOP, robot_pkg::BTN_LEFT, robot_pkg::BTN_RIGHT, robot_pkg::BTN_FAST,
        robot_pkg::BTN_SLOW, 8'h55};

    robot_top u_robot_top (.clk_50(clk_50), .reset(reset), .ir_valid(ir_valid),
        .ir_code(ir_code), .ir_ready(ir_ready), .cam_valid(cam_valid),
        .cam_direction(cam_direction), .cam_speed(cam_speed), .cam_orange(cam_orange),
        .cam_ready(cam_ready), .drive_valid(drive_valid), .drive_state(drive_state),
        .motor_restart(motor_restart), .drive_ready(drive_ready), .hex0(hex0), .hex1(hex1),
        .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7));

    always #50 clk_50 = !clk_50;

    always @(posedge clk_50) cycle <= cycle + 1;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic fail_run(input string what);
        $display("Error: %s", what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    // Expected behaviour straight from the mode and tracker rules
    function automatic void model_step(input logic is_cam, input logic [7:0] code,
        input logic [2:0] dir, input logic [1:0] speed, input logic orange,
        output logic exp, output robot_pkg::drive_cmd_e cmd, output logic chg);
        robot_pkg::mode_e      new_mode;
        robot_pkg::cam_state_e new_state;
        exp = 1'b0;
        cmd = robot_pkg::STOP;
        chg = 1'b0;
        if (!is_cam) begin
            new_mode = (code == robot_pkg::BTN_CAM) ? robot_pkg::CAM :
                       (code == robot_pkg::BTN_IR) ? robot_pkg::IR : robot_pkg::IDLE;
            if (code == robot_pkg::BTN_CAM || code == robot_pkg::BTN_IR ||
                code == robot_pkg::BTN_IDLE) begin
                exp = 1'b1;
                chg = (new_mode != m_mode);
                if (new_mode != robot_pkg::CAM) m_state = robot_pkg::PAUSE;
                else if (m_mode != robot_pkg::CAM) m_state = robot_pkg::SEARCH;
                m_mode = new_mode;
            end else if (m_mode == robot_pkg::IR) begin
                exp = 1'b1;
                if (code == robot_pkg::BTN_LEFT) cmd = robot_pkg::LEFT;
                else if (code == robot_pkg::BTN_RIGHT) cmd = robot_pkg::RIGHT;
                else if (code == robot_pkg::BTN_FAST) cmd = robot_pkg::FAST;
                else if (code == robot_pkg::BTN_SLOW) cmd = robot_pkg::SLOW;
            end
        end else if (m_mode == robot_pkg::CAM) begin
            exp = 1'b1;
            new_state = orange ? robot_pkg::FOLLOW : robot_pkg::SEARCH;
            chg = (new_state != m_state);
            m_state = new_state;
            if (dir == robot_pkg::DIR_LEFT) cmd = robot_pkg::LEFT;
            else if (dir == robot_pkg::DIR_RIGHT) cmd = robot_pkg::RIGHT;
            else if (m_state == robot_pkg::FOLLOW && dir == robot_pkg::DIR_AHEAD) begin
                if (speed == 2'd0) cmd = robot_pkg::SLOW;
                else if (speed == 2'd1) cmd = robot_pkg::MEDIUM;
                else if (speed == 2'd2) cmd = robot_pkg::FAST;
            end
        end
    endfunction

    function automatic logic [27:0] cmd_glyphs(input robot_pkg::drive_cmd_e c);
        case (c)
            robot_pkg::LEFT:   return {robot_pkg::GLYPH_L, robot_pkg::GLYPH_E,
                                       robot_pkg::GLYPH_F, robot_pkg::GLYPH_T};
            robot_pkg::RIGHT:  return {robot_pkg::GLYPH_R, robot_pkg::GLYPH_G,
                                       robot_pkg::GLYPH_H, robot_pkg::GLYPH_T};
            robot_pkg::SLOW:   return {robot_pkg::GLYPH_S, robot_pkg::GLYPH_P,
                                       robot_pkg::GLYPH_BLANK, robot_pkg::GLYPH_1};
            robot_pkg::MEDIUM: return {robot_pkg::GLYPH_S, robot_pkg::GLYPH_P,
                                       robot_pkg::GLYPH_BLANK, robot_pkg::GLYPH_2};
            robot_pkg::FAST:   return {robot_pkg::GLYPH_S, robot_pkg::GLYPH_P,
                                       robot_pkg::GLYPH_BLANK, robot_pkg::GLYPH_3};
            default:           return {robot_pkg::GLYPH_S, robot_pkg::GLYPH_T,
                                       robot_pkg::GLYPH_O, robot_pkg::GLYPH_P};
        endcase
    endfunction

    function automatic logic [13:0] mode_glyphs(input robot_pkg::mode_e m);
        if (m == robot_pkg::CAM) return {robot_pkg::GLYPH_C, robot_pkg::GLYPH_A};
        if (m == robot_pkg::IR) return {robot_pkg::GLYPH_I, robot_pkg::GLYPH_R};
        return {robot_pkg::GLYPH_I, robot_pkg::GLYPH_D};
    endfunction

    function automatic logic [6:0] state_glyph(input robot_pkg::cam_state_e s);
        if (s == robot_pkg::SEARCH) return robot_pkg::GLYPH_S;
        if (s == robot_pkg::FOLLOW) return robot_pkg::GLYPH_F;
        return robot_pkg::GLYPH_P;
    endfunction

    task automatic push_expected(input logic exp, input robot_pkg::drive_cmd_e cmd,
        input logic chg);
        if (exp) expected_q.push_back({chg, cmd});
    endtask

    task automatic send_ir(input logic [7:0] code);
        logic                  exp;
        robot_pkg::drive_cmd_e cmd;
        logic                  chg;
        int                    t;
        t = 0;
        @(posedge clk_50);
        #10;
        ir_valid = 1'b1;
        ir_code  = code;
        @(negedge clk_50);
        while (!(ir_ready === 1'b1)) begin
            @(negedge clk_50);
            t++;
            if (t > TIMEOUT) fail_run("IR code was not accepted before the timeout");
        end
        xfer_cycle = cycle;
        @(posedge clk_50);
        #10;
        ir_valid = 1'b0;
        model_step(1'b0, code, 3'd0, 2'd0, 1'b0, exp, cmd, chg);
        push_expected(exp, cmd, chg);
    endtask

    task automatic send_cam(input logic [2:0] dir, input logic [1:0] speed, input logic orange);
        logic                  exp;
        robot_pkg::drive_cmd_e cmd;
        logic                  chg;
        int                    t;
        t = 0;
        @(posedge clk_50);
        #10;
        cam_valid     = 1'b1;
        cam_direction = dir;
        cam_speed     = speed;
        cam_orange    = orange;
        @(negedge clk_50);
        while (!cam_ready) begin
            @(negedge clk_50);
            t++;
            if (t > TIMEOUT) fail_run("cam_ready stayed low past the timeout");
        end
        @(posedge clk_50);
        #10;
        cam_valid = 1'b0;
        model_step(1'b1, 8'd0, dir, speed, orange, exp, cmd, chg);
        push_expected(exp, cmd, chg);
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        @(negedge clk_50);
        while (expected_q.size() != 0 || drive_valid) begin
            @(negedge clk_50);
            t++;
            if (t > TIMEOUT) fail_run("expected motor items never arrived");
        end
        repeat (2) @(negedge clk_50);                   // Display catches up
    endtask

    task automatic random_report();
        logic [31:0] dir;
        logic [31:0] speed;
        logic [31:0] orange;
        dir    = rand_bits(2);
        speed  = rand_bits(2);
        orange = rand_bits(1);
        send_cam(dir[2:0], speed[1:0], orange[0]);
    endtask

    // Random stalls on the motor side
    always @(posedge clk_50) begin
        next_ready = stall_en ? (rand_bits(1) != 32'd0) : 1'b1;
        #10;
        drive_ready = next_ready;
    end

    // Compare process, also checks the hold rule while stalled
    logic                  was_stalled = 1'b0;
    robot_pkg::drive_cmd_e held_state;
    logic                  held_restart;
    logic [3:0]            item;
    always @(negedge clk_50) begin
        if (!reset) begin
            if (was_stalled) begin
                check_value("hold valid", 1, drive_valid);
                check_value("hold state", held_state, drive_state);
                check_value("hold restart", held_restart, motor_restart);
            end
            if (drive_valid && drive_ready) begin
                if (expected_q.size() == 0) fail_run("motor item arrived when none was expected");
                item = expected_q.pop_front();
                check_value("drive_state", item[2:0], drive_state);
                check_value("motor_restart", item[3], motor_restart);
            end
            was_stalled  = drive_valid && !drive_ready;
            held_state   = drive_state;
            held_restart = motor_restart;
        end
    end

    logic [31:0] pick;
    int          t;
    initial begin
        clk_50 = 1'b0;
        reset = 1'b1;
        ir_valid = 1'b0;
        ir_code = 8'd0;
        cam_valid = 1'b0;
        cam_direction = 3'd0;
        cam_speed = 2'd0;
        cam_orange = 1'b0;
        drive_ready = 1'b1;
        repeat (8) @(posedge clk_50);
        #10;
        reset = 1'b0;
        check_value("reset drive_valid", 0, drive_valid);

        // Mode buttons and mode glyphs
        foreach (codes[i]) begin
            if (i < 3) begin
                send_ir(codes[i]);
                send_ir(codes[i]);
                wait_idle();
                check_value("mode glyphs", mode_glyphs(m_mode), {hex7, hex6});
                check_value("spacer glyph", robot_pkg::GLYPH_BLANK, hex5);
            end
        end

        // IR manual drive, then drive buttons in IDLE
        send_ir(robot_pkg::BTN_IR);
        for (int i = 3; i < 9; i++) send_ir(codes[i]);
        wait_idle();
        send_ir(robot_pkg::BTN_IDLE);
        for (int i = 3; i < 9; i++) send_ir(codes[i]);
        repeat (5) @(posedge clk_50);
        wait_idle();

        // Camera tracking
        send_ir(robot_pkg::BTN_CAM);
        for (int i = 0; i < 40; i++) begin
            random_report();
            wait_idle();
            check_value("tracker glyph", state_glyph(m_state), hex4);
        end

        // Draining outside camera mode
        send_ir(robot_pkg::BTN_IDLE);
        for (int i = 0; i < 8; i++) random_report();
        send_ir(robot_pkg::BTN_IR);
        for (int i = 0; i < 8; i++) random_report();
        wait_idle();

        // Mixed traffic with stalls
        stall_en = 1'b1;
        for (int i = 0; i < 80; i++) begin
            pick = rand_bits(2);
            case (pick[1:0])
                2'd0: begin
                    wait_idle();                        // Mode change on an empty path
                    send_ir(codes[rand_bits(4) % 3]);
                end
                2'd1: send_ir(codes[3 + rand_bits(4) % 6]);
                default: random_report();
            endcase
        end
        wait_idle();
        stall_en = 1'b0;

        // Latency and command glyphs
        send_ir(robot_pkg::BTN_IR);
        wait_idle();
        if (!ir_ready) fail_run("ir_ready low on an empty path");
        send_ir(robot_pkg::BTN_LEFT);
        t = 0;
        while (!drive_valid) begin
            @(negedge clk_50);
            t++;
            if (t > TIMEOUT) fail_run("drive_valid never rose");
        end
        check_value("latency", 2, cycle - xfer_cycle);
        @(negedge clk_50);
        check_value("command glyphs", cmd_glyphs(robot_pkg::LEFT), {hex3, hex2, hex1, hex0});
        wait_idle();

        if (expected_q.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Error: %0d expected motor items missing", expected_q.size());
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    // Global limit on the whole run
    initial begin
        #5000000;
        fail_run("simulation ran past its time limit");
    end

endmodule

// ==== filelist.f ====
source/robot_pkg.sv
source/drive_req_if.sv
source/ir_command_decoder.sv
source/cam_tracker.sv
source/drive_arbiter.sv
source/status_display.sv
source/robot_top.sv
bench/tb_robot.sv

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing -f filelist.f --top-module tb_robot -o sim_robot

output=$(./obj_dir/sim_robot) || true
echo "$output"

if echo "$output" | grep -q "STATUS: PASS"; then
    exit 0
fi
exit 1

// ==== source/cam_tracker.sv ====
module cam_tracker (
    input  logic                  clk_50,
    input  logic                  reset,
    input  robot_pkg::mode_e      mode,
    input  logic                  cam_valid,
    input  logic [2:0]            cam_direction,
    input  logic [1:0]            cam_speed,
    input  logic                  cam_orange,
    output logic                  cam_ready,
    output robot_pkg::cam_state_e cam_state,
    drive_req_if.source           req
);

    logic                  take;
    robot_pkg::cam_state_e base_state;
    robot_pkg::cam_state_e next_state;
    robot_pkg::drive_cmd_e report_cmd;

    assign cam_ready = !req.valid || req.ready;
    assign take      = cam_valid && cam_ready;

    // A report in the cycle CAM is entered starts from SEARCH
    assign base_state = (cam_state == robot_pkg::PAUSE) ? robot_pkg::SEARCH : cam_state;

    always_comb begin
        if (cam_orange) begin
            next_state = robot_pkg::FOLLOW;
        end else begin
            next_state = robot_pkg::SEARCH;
        end
    end

    always_comb begin
        report_cmd = robot_pkg::STOP;
        if (cam_direction == robot_pkg::DIR_LEFT) begin
            report_cmd = robot_pkg::LEFT;
        end else if (cam_direction == robot_pkg::DIR_RIGHT) begin
            report_cmd = robot_pkg::RIGHT;
        end else if (next_state == robot_pkg::FOLLOW && cam_direction == robot_pkg::DIR_AHEAD) begin
            case (cam_speed)
                2'd0:    report_cmd = robot_pkg::SLOW;
                2'd1:    report_cmd = robot_pkg::MEDIUM;
                2'd2:    report_cmd = robot_pkg::FAST;
                default: report_cmd = robot_pkg::STOP;
            endcase
        end
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            cam_state <= robot_pkg::PAUSE;
            req.valid <= 1'b0;
        end else begin
            if (req.valid && req.ready) begin
                req.valid <= 1'b0;
            end
            if (mode != robot_pkg::CAM) begin
                cam_state <= robot_pkg::PAUSE;      // Reports here are dropped
            end else if (take) begin
                cam_state <= next_state;
                req.valid <= 1'b1;
            end else if (cam_state == robot_pkg::PAUSE) begin
                cam_state <= robot_pkg::SEARCH;
            end
        end
    end

    always_ff @(posedge clk_50) begin
        if (take) begin
            req.cmd     <= report_cmd;
            req.changed <= (next_state != base_state);
        end
    end

endmodule

// ==== source/drive_arbiter.sv ====
module drive_arbiter (
    input  logic                   clk_50,
    input  logic                   reset,
    input  robot_pkg::mode_e       mode,
    drive_req_if.sink              ir_req,
    drive_req_if.sink              cam_req,
    output logic                   drive_valid,
    input  logic                   drive_ready,
    output robot_pkg::drive_cmd_e  drive_state,
    output logic                   motor_restart
);

    logic out_free;         // Output register empty or leaving now
    logic cam_mode;
    logic ir_take;
    logic cam_take;

    assign out_free = !drive_valid || drive_ready;
    assign cam_mode = (mode == robot_pkg::CAM);

    assign ir_req.ready = out_free;

    // Outside camera mode the tracker stream is flushed
    always_comb begin
        if (cam_mode) begin
            cam_req.ready = out_free && !ir_req.valid;    // IR has priority
        end else begin
            cam_req.ready = 1'b1;
        end
    end

    assign ir_take  = ir_req.valid && ir_req.ready;
    assign cam_take = cam_mode && cam_req.valid && cam_req.ready;

    always_ff @(posedge clk_50) begin
        if (reset) begin
            drive_valid   <= 1'b0;
            drive_state   <= robot_pkg::STOP;
            motor_restart <= 1'b0;
        end else begin
            if (drive_valid && drive_ready) begin
                drive_valid <= 1'b0;
            end
            if (ir_take) begin
                drive_valid   <= 1'b1;
                drive_state   <= ir_req.cmd;
                motor_restart <= ir_req.changed;
            end else if (cam_take) begin
                drive_valid   <= 1'b1;
                drive_state   <= cam_req.cmd;
                motor_restart <= cam_req.changed;
            end
        end
    end

endmodule

// ==== source/drive_req_if.sv ====
interface drive_req_if;

    logic                  valid;
    logic                  ready;
    robot_pkg::drive_cmd_e cmd;
    logic                  changed;    // Sender state moved with this item

    modport source (
        output valid, cmd, changed,
        input  ready
    );

    modport sink (
        input  valid, cmd, changed,
        output ready
    );

endinterface

// ==== source/ir_command_decoder.sv ====
module ir_command_decoder (
    input  logic             clk_50,
    input  logic             reset,
    input  logic             ir_valid,
    input  logic [7:0]       ir_code,
    output logic             ir_ready,
    output robot_pkg::mode_e mode,
    drive_req_if.source      req
);

    logic                  ready_en;       // Low only while coming out of reset
    logic                  take;
    logic                  is_mode_btn;
    robot_pkg::mode_e      btn_mode;
    robot_pkg::drive_cmd_e btn_cmd;

    assign ir_ready = ready_en && (!req.valid || req.ready);
    assign take     = ir_valid && ir_ready;

    always_comb begin
        is_mode_btn = 1'b1;
        btn_mode    = mode;
        case (ir_code)
            robot_pkg::BTN_CAM:  btn_mode = robot_pkg::CAM;
            robot_pkg::BTN_IR:   btn_mode = robot_pkg::IR;
            robot_pkg::BTN_IDLE: btn_mode = robot_pkg::IDLE;
            default:             is_mode_btn = 1'b0;
        endcase
    end

    // Manual drive map, anything unknown stops the car
    always_comb begin
        case (ir_code)
            robot_pkg::BTN_LEFT:  btn_cmd = robot_pkg::LEFT;
            robot_pkg::BTN_RIGHT: btn_cmd = robot_pkg::RIGHT;
            robot_pkg::BTN_FAST:  btn_cmd = robot_pkg::FAST;
            robot_pkg::BTN_SLOW:  btn_cmd = robot_pkg::SLOW;
            default:              btn_cmd = robot_pkg::STOP;
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            ready_en  <= 1'b0;
            mode      <= robot_pkg::IDLE;
            req.valid <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (req.valid && req.ready) begin
                req.valid <= 1'b0;                  // Arbiter took it
            end
            if (take) begin
                if (is_mode_btn) begin
                    mode      <= btn_mode;
                    req.valid <= 1'b1;
                end else if (mode == robot_pkg::IR) begin
                    req.valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_50) begin
        if (take) begin
            if (is_mode_btn) begin
                req.cmd     <= robot_pkg::STOP;     // Mode switch always halts
                req.changed <= (btn_mode != mode);
            end else begin
                req.cmd     <= btn_cmd;
                req.changed <= 1'b0;
            end
        end
    end

endmodule

// ==== source/robot_pkg.sv ====
package robot_pkg;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        CAM  = 2'b01,
        IR   = 2'b10
    } mode_e;

    typedef enum logic [1:0] {
        SEARCH = 2'b00,
        FOLLOW = 2'b01,
        PAUSE  = 2'b11               // Parked while not in camera mode
    } cam_state_e;

    typedef enum logic [2:0] {
        STOP   = 3'b000,
        LEFT   = 3'b001,
        RIGHT  = 3'b010,
        SLOW   = 3'b011,
        MEDIUM = 3'b100,
        FAST   = 3'b101
    } drive_cmd_e;

    // Remote button codes
    localparam logic [7:0] BTN_CAM   = 8'h0F;
    localparam logic [7:0] BTN_IR    = 8'h13;
    localparam logic [7:0] BTN_IDLE  = 8'h10;
    localparam logic [7:0] BTN_STOP  = 8'h0C;
    localparam logic [7:0] BTN_LEFT  = 8'h14;
    localparam logic [7:0] BTN_RIGHT = 8'h18;
    localparam logic [7:0] BTN_FAST  = 8'h1B;
    localparam logic [7:0] BTN_SLOW  = 8'h1F;

    localparam logic [2:0] DIR_LEFT  = 3'd1;     // Camera direction field
    localparam logic [2:0] DIR_RIGHT = 3'd2;
    localparam logic [2:0] DIR_AHEAD = 3'd3;

    // Seven-segment patterns, active low, bit 6 is segment g
    localparam logic [6:0] GLYPH_A     = 7'b0001000;
    localparam logic [6:0] GLYPH_C     = 7'b1000110;
    localparam logic [6:0] GLYPH_D     = 7'b0100001;     // Lower case d
    localparam logic [6:0] GLYPH_E     = 7'b0000110;
    localparam logic [6:0] GLYPH_F     = 7'b0001110;
    localparam logic [6:0] GLYPH_G     = 7'b0000010;
    localparam logic [6:0] GLYPH_H     = 7'b0001001;
    localparam logic [6:0] GLYPH_I     = 7'b1111001;
    localparam logic [6:0] GLYPH_L     = 7'b1000111;
    localparam logic [6:0] GLYPH_O     = 7'b1000000;
    localparam logic [6:0] GLYPH_P     = 7'b0001100;
    localparam logic [6:0] GLYPH_R     = 7'b0101111;     // Lower case r
    localparam logic [6:0] GLYPH_S     = 7'b0010010;
    localparam logic [6:0] GLYPH_T     = 7'b0001111;     // Lower case t
    localparam logic [6:0] GLYPH_1     = 7'b1111001;
    localparam logic [6:0] GLYPH_2     = 7'b0100100;
    localparam logic [6:0] GLYPH_3     = 7'b0110000;
    localparam logic [6:0] GLYPH_BLANK = 7'b1111111;

endpackage

// ==== source/robot_top.sv ====
module robot_top (
    input  logic                  clk_50,
    input  logic                  reset,
    input  logic                  ir_valid,
    input  logic [7:0]            ir_code,
    output logic                  ir_ready,
    input  logic                  cam_valid,
    input  logic [2:0]            cam_direction,
    input  logic [1:0]            cam_speed,
    input  logic                  cam_orange,
    output logic                  cam_ready,
    output logic                  drive_valid,
    output robot_pkg::drive_cmd_e drive_state,
    output logic                  motor_restart,
    input  logic                  drive_ready,
    output logic [6:0]            hex0,
    output logic [6:0]            hex1,
    output logic [6:0]            hex2,
    output logic [6:0]            hex3,
    output logic [6:0]            hex4,
    output logic [6:0]            hex5,
    output logic [6:0]            hex6,
    output logic [6:0]            hex7
);

    robot_pkg::mode_e      mode;
    robot_pkg::cam_state_e cam_state;

    drive_req_if ir_req ();
    drive_req_if cam_req ();

    ir_command_decoder u_ir_command_decoder (.clk_50(clk_50), .reset(reset),
        .ir_valid(ir_valid), .ir_code(ir_code), .ir_ready(ir_ready), .mode(mode),
        .req(ir_req.source));

    cam_tracker u_cam_tracker (.clk_50(clk_50), .reset(reset), .mode(mode),
        .cam_valid(cam_valid), .cam_direction(cam_direction), .cam_speed(cam_speed),
        .cam_orange(cam_orange), .cam_ready(cam_ready), .cam_state(cam_state),
        .req(cam_req.source));

    drive_arbiter u_drive_arbiter (.clk_50(clk_50), .reset(reset), .mode(mode),
        .ir_req(ir_req.sink), .cam_req(cam_req.sink), .drive_valid(drive_valid),
        .drive_ready(drive_ready), .drive_state(drive_state),
        .motor_restart(motor_restart));

    status_display u_status_display (.clk_50(clk_50), .reset(reset), .mode(mode),
        .cam_state(cam_state), .drive_state(drive_state), .hex0(hex0), .hex1(hex1),
        .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7));

endmodule

// ==== source/status_display.sv ====
module status_display (
    input  logic                  clk_50,
    input  logic                  reset,
    input  robot_pkg::mode_e      mode,
    input  robot_pkg::cam_state_e cam_state,
    input  robot_pkg::drive_cmd_e drive_state,
    output logic [6:0]            hex0,
    output logic [6:0]            hex1,
    output logic [6:0]            hex2,
    output logic [6:0]            hex3,
    output logic [6:0]            hex4,
    output logic [6:0]            hex5,
    output logic [6:0]            hex6,
    output logic [6:0]            hex7
);

    always_ff @(posedge clk_50) begin
        if (reset) begin
            {hex7, hex6, hex5, hex4} <= {4{robot_pkg::GLYPH_BLANK}};
            {hex3, hex2, hex1, hex0} <= {4{robot_pkg::GLYPH_BLANK}};
        end else begin
            hex5 <= robot_pkg::GLYPH_BLANK;             // Spacer digit
            case (mode)
                robot_pkg::CAM: {hex7, hex6} <= {robot_pkg::GLYPH_C, robot_pkg::GLYPH_A};
                robot_pkg::IR:  {hex7, hex6} <= {robot_pkg::GLYPH_I, robot_pkg::GLYPH_R};
                default:        {hex7, hex6} <= {robot_pkg::GLYPH_I, robot_pkg::GLYPH_D};
            endcase
            case (cam_state)
                robot_pkg::SEARCH: hex4 <= robot_pkg::GLYPH_S;
                robot_pkg::FOLLOW: hex4 <= robot_pkg::GLYPH_F;
                default:           hex4 <= robot_pkg::GLYPH_P;
            endcase
            case (drive_state)
                robot_pkg::LEFT: {hex3, hex2, hex1, hex0} <= {robot_pkg::GLYPH_L,
                    robot_pkg::GLYPH_E, robot_pkg::GLYPH_F, robot_pkg::GLYPH_T};
                robot_pkg::RIGHT: {hex3, hex2, hex1, hex0} <= {robot_pkg::GLYPH_R,
                    robot_pkg::GLYPH_G, robot_pkg::GLYPH_H, robot_pkg::GLYPH_T};
                robot_pkg::SLOW: {hex3, hex2, hex1, hex0} <= {robot_pkg::GLYPH_S,
                    robot_pkg::GLYPH_P, robot_pkg::GLYPH_BLANK, robot_pkg::GLYPH_1};
                robot_pkg::MEDIUM: {hex3, hex2, hex1, hex0} <= {robot_pkg::GLYPH_S,
                    robot_pkg::GLYPH_P, robot_pkg::GLYPH_BLANK, robot_pkg::GLYPH_2};
                robot_pkg::FAST: {hex3, hex2, hex1, hex0} <= {robot_pkg::GLYPH_S,
                    robot_pkg::GLYPH_P, robot_pkg::GLYPH_BLANK, robot_pkg::GLYPH_3};
                default: {hex3, hex2, hex1, hex0} <= {robot_pkg::GLYPH_S,
                    robot_pkg::GLYPH_T, robot_pkg::GLYPH_O, robot_pkg::GLYPH_P};
            endcase
        end
    end

endmodule
